// File: common/la_decode_pkg.sv
package la_decode_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int ALU_OP_W   = 12;
  localparam int BYTE_EN_W  = 4;

  // link register for bl
  localparam logic [REG_ADDR_W-1:0] RA_REG = 5'd1;

  // major opcode, bits 31:26
  localparam logic [5:0] OP6_ALU  = 6'h00;
  localparam logic [5:0] OP6_MEM  = 6'h0a;
  localparam logic [5:0] OP6_JIRL = 6'h13;
  localparam logic [5:0] OP6_B    = 6'h14;
  localparam logic [5:0] OP6_BL   = 6'h15;
  localparam logic [5:0] OP6_BEQ  = 6'h16;
  localparam logic [5:0] OP6_BNE  = 6'h17;
  localparam logic [5:0] OP6_BLT  = 6'h18;
  localparam logic [5:0] OP6_BGE  = 6'h19;
  localparam logic [5:0] OP6_BLTU = 6'h1a;
  localparam logic [5:0] OP6_BGEU = 6'h1b;

  // 1ri20 forms, bits 31:25
  localparam logic [6:0] OP7_LU12I  = 7'h0a;
  localparam logic [6:0] OP7_PCADDU = 7'h0e;

  // alu group, bits 25:22
  localparam logic [3:0] OP4_3R     = 4'h0;
  localparam logic [3:0] OP4_SHIFTI = 4'h1;
  localparam logic [3:0] OP4_SLTI   = 4'h8;
  localparam logic [3:0] OP4_SLTUI  = 4'h9;
  localparam logic [3:0] OP4_ADDI   = 4'ha;
  localparam logic [3:0] OP4_ANDI   = 4'hd;
  localparam logic [3:0] OP4_ORI    = 4'he;
  localparam logic [3:0] OP4_XORI   = 4'hf;

  // memory group, bits 25:22
  localparam logic [3:0] OP4_LD_B  = 4'h0;
  localparam logic [3:0] OP4_LD_H  = 4'h1;
  localparam logic [3:0] OP4_LD_W  = 4'h2;
  localparam logic [3:0] OP4_ST_B  = 4'h4;
  localparam logic [3:0] OP4_ST_H  = 4'h5;
  localparam logic [3:0] OP4_ST_W  = 4'h6;
  localparam logic [3:0] OP4_LD_BU = 4'h8;
  localparam logic [3:0] OP4_LD_HU = 4'h9;

  // bits 21:20
  localparam logic [1:0] OP2_3R     = 2'h1;
  localparam logic [1:0] OP2_SHIFTI = 2'h0;

  // bits 19:15
  localparam logic [4:0] OP5_ADD  = 5'h00;
  localparam logic [4:0] OP5_SUB  = 5'h02;
  localparam logic [4:0] OP5_SLT  = 5'h04;
  localparam logic [4:0] OP5_SLTU = 5'h05;
  localparam logic [4:0] OP5_NOR  = 5'h08;
  localparam logic [4:0] OP5_AND  = 5'h09;
  localparam logic [4:0] OP5_OR   = 5'h0a;
  localparam logic [4:0] OP5_XOR  = 5'h0b;
  localparam logic [4:0] OP5_SLL  = 5'h0e;
  localparam logic [4:0] OP5_SRL  = 5'h0f;
  localparam logic [4:0] OP5_SRA  = 5'h10;
  localparam logic [4:0] OP5_SLLI = 5'h01;
  localparam logic [4:0] OP5_SRLI = 5'h09;
  localparam logic [4:0] OP5_SRAI = 5'h11;

  typedef union packed {
    struct packed {
      logic [5:0]            op6;
      logic [3:0]            op4;
      logic [1:0]            op2;
      logic [4:0]            op5;
      logic [REG_ADDR_W-1:0] rk;
      logic [REG_ADDR_W-1:0] rj;
      logic [REG_ADDR_W-1:0] rd;
    } fmt_3r;
    struct packed {
      logic [5:0]            op6;
      logic [3:0]            op4;
      logic [11:0]           si12;
      logic [REG_ADDR_W-1:0] rj;
      logic [REG_ADDR_W-1:0] rd;
    } fmt_2ri12;
    struct packed {
      logic [5:0]            op6;
      logic [15:0]           off16;
      logic [REG_ADDR_W-1:0] rj;
      logic [REG_ADDR_W-1:0] rd;
    } fmt_2ri16;
    struct packed {
      logic [6:0]            op7;
      logic [19:0]           si20;
      logic [REG_ADDR_W-1:0] rd;
    } fmt_1ri20;
  } instr_u;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    instr_u          instr;
    logic            pc_is_jump;
  } if_slot_t;

  // one bit per kept instruction
  typedef struct packed {
    logic add_w;
    logic sub_w;
    logic slt;
    logic sltu;
    logic nor_r;
    logic and_r;
    logic or_r;
    logic xor_r;
    logic sll_w;
    logic srl_w;
    logic sra_w;
    logic slli_w;
    logic srli_w;
    logic srai_w;
    logic slti;
    logic sltui;
    logic addi_w;
    logic andi;
    logic ori;
    logic xori;
    logic ld_b;
    logic ld_h;
    logic ld_w;
    logic ld_bu;
    logic ld_hu;
    logic st_b;
    logic st_h;
    logic st_w;
    logic jirl;
    logic b;
    logic bl;
    logic beq;
    logic bne;
    logic blt;
    logic bge;
    logic bltu;
    logic bgeu;
    logic lu12i_w;
    logic pcaddu;
  } inst_hit_t;

  typedef struct packed {
    logic [ALU_OP_W-1:0]   alu_op;
    logic [BYTE_EN_W-1:0]  bit_width;
    logic                  may_jump;
    logic                  use_rj_value;
    logic                  use_less;
    logic                  need_less;
    logic                  use_zero;
    logic                  need_zero;
    logic                  src1_is_pc;
    logic                  src2_is_imm;
    logic                  src2_is_4;
    logic                  gr_we;
    logic                  mem_we;
    logic                  res_from_mem;
    logic                  is_unsigned;
    logic [REG_ADDR_W-1:0] dest;
    logic [XLEN-1:0]       imm;
  } ex_ctrl_t;

  typedef struct packed {
    ex_ctrl_t        ctrl;
    logic [XLEN-1:0] rj_value;
    logic [XLEN-1:0] rkd_value;
    logic [XLEN-1:0] pc;
    logic            pc_is_jump;
  } ex_bundle_t;

  typedef struct packed {
    logic [REG_ADDR_W-1:0] dest;
    logic                  gr_we;
    logic                  use_rj;
    logic                  use_rkd;
    logic                  may_jump;
    logic                  is_ls;
  } hazard_t;

endpackage

// File: decoder/ctrl_gen.sv
`timescale 1ns/100ps
module ctrl_gen (
  input  la_decode_pkg::instr_u                     instr,
  input  la_decode_pkg::inst_hit_t                  hits,
  output la_decode_pkg::ex_ctrl_t                   ctrl,
  output logic [la_decode_pkg::REG_ADDR_W-1:0]      raddr_rj,
  output logic [la_decode_pkg::REG_ADDR_W-1:0]      raddr_rkd,
  output la_decode_pkg::hazard_t                    hz
);
  import la_decode_pkg::*;

  logic [REG_ADDR_W-1:0] rd;
  logic [REG_ADDR_W-1:0] rj;
  logic [REG_ADDR_W-1:0] rk;
  logic [11:0] si12;
  logic [15:0] off16;
  logic is_load;
  logic is_store;
  logic cond_br;
  logic need_ui5;
  logic need_si12;
  logic need_si12_u;
  logic need_si16;
  logic need_si20;
  logic need_si26;

  assign rd    = instr.fmt_3r.rd;
  assign rj    = instr.fmt_3r.rj;
  assign rk    = instr.fmt_3r.rk;
  assign si12  = instr.fmt_2ri12.si12;
  assign off16 = instr.fmt_2ri16.off16;

  assign is_load  = hits.ld_b | hits.ld_h | hits.ld_w | hits.ld_bu | hits.ld_hu;
  assign is_store = hits.st_b | hits.st_h | hits.st_w;
  assign cond_br  = hits.beq | hits.bne | hits.blt | hits.bge | hits.bltu | hits.bgeu;

  assign need_ui5    = hits.slli_w | hits.srli_w | hits.srai_w;
  assign need_si12   = hits.addi_w | hits.slti | hits.sltui | is_load | is_store;
  assign need_si12_u = hits.andi | hits.ori | hits.xori;
  assign need_si16   = hits.jirl | cond_br;
  assign need_si20   = hits.lu12i_w | hits.pcaddu;
  assign need_si26   = hits.b | hits.bl;

  always_comb begin
    // add also forms addresses and link values
    ctrl.alu_op[0]  = hits.add_w | hits.addi_w | is_load | is_store | hits.jirl |
                      hits.bl | hits.pcaddu;
    ctrl.alu_op[1]  = hits.sub_w | hits.beq | hits.bne;
    ctrl.alu_op[2]  = hits.slt | hits.slti | hits.blt | hits.bge;
    ctrl.alu_op[3]  = hits.sltu | hits.sltui | hits.bltu | hits.bgeu;
    ctrl.alu_op[4]  = hits.and_r | hits.andi;
    ctrl.alu_op[5]  = hits.nor_r;
    ctrl.alu_op[6]  = hits.or_r | hits.ori;
    ctrl.alu_op[7]  = hits.xor_r | hits.xori;
    ctrl.alu_op[8]  = hits.sll_w | hits.slli_w;
    ctrl.alu_op[9]  = hits.srl_w | hits.srli_w;
    ctrl.alu_op[10] = hits.sra_w | hits.srai_w;
    ctrl.alu_op[11] = hits.lu12i_w;

    if (hits.ld_w | hits.st_w)
      ctrl.bit_width = 4'hf;
    else if (hits.ld_h | hits.ld_hu | hits.st_h)
      ctrl.bit_width = 4'h3;
    else if (hits.ld_b | hits.ld_bu | hits.st_b)
      ctrl.bit_width = 4'h1;
    else
      ctrl.bit_width = 4'h0;

    ctrl.may_jump     = cond_br | hits.jirl | hits.b | hits.bl;
    ctrl.use_rj_value = hits.jirl;
    ctrl.use_less     = hits.blt | hits.bltu | hits.bge | hits.bgeu;
    ctrl.need_less    = hits.blt | hits.bltu;
    ctrl.use_zero     = hits.beq | hits.bne;
    ctrl.need_zero    = hits.beq;
    ctrl.src1_is_pc   = hits.jirl | hits.bl | hits.pcaddu;
    ctrl.src2_is_imm  = need_ui5 | need_si12 | need_si12_u | need_si20;
    ctrl.src2_is_4    = hits.jirl | hits.bl;
    ctrl.gr_we        = hits.add_w | hits.sub_w | hits.slt | hits.sltu | hits.nor_r |
                        hits.and_r | hits.or_r | hits.xor_r | hits.sll_w | hits.srl_w |
                        hits.sra_w | need_ui5 | hits.slti | hits.sltui | hits.addi_w |
                        need_si12_u | is_load | hits.jirl | hits.bl | need_si20;
    ctrl.mem_we       = is_store;
    ctrl.res_from_mem = is_load;
    ctrl.is_unsigned  = hits.ld_bu | hits.ld_hu;
    ctrl.dest         = hits.bl ? RA_REG : rd;

    if (need_si20)
      ctrl.imm = {instr.fmt_1ri20.si20, 12'b0};
    else if (need_ui5)
      ctrl.imm = {{(XLEN-REG_ADDR_W){1'b0}}, rk};
    else if (need_si26)
      ctrl.imm = {{6{rj[4]}}, rj, rd, off16};
    else if (need_si16)
      ctrl.imm = {{16{off16[15]}}, off16};
    else if (need_si12_u)
      ctrl.imm = {20'b0, si12};
    else if (need_si12)
      ctrl.imm = {{20{si12[11]}}, si12};
    else
      ctrl.imm = '0;
  end

  // branches and stores compare or write rd
  assign raddr_rj  = rj;
  assign raddr_rkd = (cond_br | is_store) ? rd : rk;

  always_comb begin
    hz.dest     = ctrl.dest;
    hz.gr_we    = ctrl.gr_we;
    hz.use_rj   = ctrl.use_rj_value | ~ctrl.src1_is_pc;
    hz.use_rkd  = ~(ctrl.src2_is_imm | ctrl.src2_is_4);
    hz.may_jump = ctrl.may_jump;
    hz.is_ls    = |ctrl.bit_width;
  end

  a_no_store_write: assert final (!(ctrl.mem_we && ctrl.gr_we))
    else $error("ctrl_gen: store also writes a register");

endmodule

// File: decoder/op_match.sv
`timescale 1ns/100ps
module op_match (
  input  la_decode_pkg::instr_u    instr,
  output la_decode_pkg::inst_hit_t hits
);
  import la_decode_pkg::*;

  logic grp_alu;
  logic grp_3r;
  logic grp_shift;
  logic grp_mem;
  logic [4:0] op5;
  logic [3:0] op4;
  logic [5:0] op6;

  assign op6 = instr.fmt_2ri16.op6;
  assign op4 = instr.fmt_2ri12.op4;
  assign op5 = instr.fmt_3r.op5;

  assign grp_alu   = op6 == OP6_ALU;
  assign grp_3r    = grp_alu && op4 == OP4_3R && instr.fmt_3r.op2 == OP2_3R;
  assign grp_shift = grp_alu && op4 == OP4_SHIFTI && instr.fmt_3r.op2 == OP2_SHIFTI;
  assign grp_mem   = op6 == OP6_MEM;

  always_comb begin
    // register forms
    hits.add_w  = grp_3r && op5 == OP5_ADD;
    hits.sub_w  = grp_3r && op5 == OP5_SUB;
    hits.slt    = grp_3r && op5 == OP5_SLT;
    hits.sltu   = grp_3r && op5 == OP5_SLTU;
    hits.nor_r  = grp_3r && op5 == OP5_NOR;
    hits.and_r  = grp_3r && op5 == OP5_AND;
    hits.or_r   = grp_3r && op5 == OP5_OR;
    hits.xor_r  = grp_3r && op5 == OP5_XOR;
    hits.sll_w  = grp_3r && op5 == OP5_SLL;
    hits.srl_w  = grp_3r && op5 == OP5_SRL;
    hits.sra_w  = grp_3r && op5 == OP5_SRA;
    hits.slli_w = grp_shift && op5 == OP5_SLLI;
    hits.srli_w = grp_shift && op5 == OP5_SRLI;
    hits.srai_w = grp_shift && op5 == OP5_SRAI;
    // 12-bit immediate forms
    hits.slti   = grp_alu && op4 == OP4_SLTI;
    hits.sltui  = grp_alu && op4 == OP4_SLTUI;
    hits.addi_w = grp_alu && op4 == OP4_ADDI;
    hits.andi   = grp_alu && op4 == OP4_ANDI;
    hits.ori    = grp_alu && op4 == OP4_ORI;
    hits.xori   = grp_alu && op4 == OP4_XORI;
    hits.ld_b   = grp_mem && op4 == OP4_LD_B;
    hits.ld_h   = grp_mem && op4 == OP4_LD_H;
    hits.ld_w   = grp_mem && op4 == OP4_LD_W;
    hits.ld_bu  = grp_mem && op4 == OP4_LD_BU;
    hits.ld_hu  = grp_mem && op4 == OP4_LD_HU;
    hits.st_b   = grp_mem && op4 == OP4_ST_B;
    hits.st_h   = grp_mem && op4 == OP4_ST_H;
    hits.st_w   = grp_mem && op4 == OP4_ST_W;
    // branches and jumps, major opcode only
    hits.jirl   = op6 == OP6_JIRL;
    hits.b      = op6 == OP6_B;
    hits.bl     = op6 == OP6_BL;
    hits.beq    = op6 == OP6_BEQ;
    hits.bne    = op6 == OP6_BNE;
    hits.blt    = op6 == OP6_BLT;
    hits.bge    = op6 == OP6_BGE;
    hits.bltu   = op6 == OP6_BLTU;
    hits.bgeu   = op6 == OP6_BGEU;
    hits.lu12i_w = instr.fmt_1ri20.op7 == OP7_LU12I;
    hits.pcaddu  = instr.fmt_1ri20.op7 == OP7_PCADDU;
  end

  // groups must not overlap in the encoding space
  a_hits_onehot: assert final ($onehot0(hits))
    else $error("op_match: more than one instruction hit for %h", instr);

endmodule

// File: hdl/dual_issue.sv
`timescale 1ns/100ps
module dual_issue (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  if_valid0,
  input  logic                                  if_valid1,
  input  la_decode_pkg::hazard_t                hz0,
  input  la_decode_pkg::hazard_t                hz1,
  input  logic [la_decode_pkg::REG_ADDR_W-1:0]  raddr1_rj,
  input  logic [la_decode_pkg::REG_ADDR_W-1:0]  raddr1_rkd,
  input  la_decode_pkg::ex_bundle_t             bundle0,
  input  la_decode_pkg::ex_bundle_t             bundle1,
  input  logic                                  ex_ready,
  input  logic                                  flush,
  output logic [1:0]                            pop,
  output la_decode_pkg::ex_bundle_t             ex_instr0,
  output la_decode_pkg::ex_bundle_t             ex_instr1,
  output logic                                  ex_valid0,
  output logic                                  ex_valid1
);

  logic raw_hit;
  logic need_single;
  logic issue0;
  logic issue1;

  // slot 1 reads what slot 0 writes
  assign raw_hit = hz0.gr_we && (|hz0.dest) &&
                   ((hz0.dest == raddr1_rj && hz1.use_rj) ||
                    (hz0.dest == raddr1_rkd && hz1.use_rkd));

  assign need_single = hz0.may_jump | hz0.is_ls | hz1.is_ls | raw_hit;

  assign issue0 = if_valid0;
  // slot 1 never goes alone
  assign issue1 = if_valid0 & if_valid1 & ~need_single;

  assign pop = {issue1 & ex_ready, issue0 & ex_ready};

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      ex_instr0 <= '0;
      ex_instr1 <= '0;
      ex_valid0 <= 1'b0;
      ex_valid1 <= 1'b0;
    end else if (ex_ready) begin
      ex_instr0 <= bundle0;
      ex_instr1 <= bundle1;
      ex_valid0 <= issue0;
      ex_valid1 <= issue1;
    end
  end

  a_valid_order: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid1 |-> ex_valid0)
    else $error("dual_issue: slot 1 valid without slot 0");

  a_stall_no_pop: assert property (@(posedge clk) disable iff (!rst_n)
    !ex_ready |-> pop == 2'b00)
    else $error("dual_issue: pop while execute stalls");

  a_pop_order: assert property (@(posedge clk) disable iff (!rst_n)
    pop[1] |-> pop[0])
    else $error("dual_issue: slot 1 popped ahead of slot 0");

endmodule

// File: hdl/id_stage.sv
`timescale 1ns/100ps
module id_stage (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  la_decode_pkg::if_slot_t                     if_slot0,
  input  la_decode_pkg::if_slot_t                     if_slot1,
  input  logic                                        if_valid0,
  input  logic                                        if_valid1,
  input  logic [3:0][la_decode_pkg::XLEN-1:0]         rf_rdata,
  input  logic                                        ex_ready,
  input  logic                                        flush,
  output logic [1:0]                                  pop,
  output logic [3:0][la_decode_pkg::REG_ADDR_W-1:0]   rf_raddr,
  output la_decode_pkg::ex_bundle_t                   ex_instr0,
  output la_decode_pkg::ex_bundle_t                   ex_instr1,
  output logic                                        ex_valid0,
  output logic                                        ex_valid1
);
  import la_decode_pkg::*;

  inst_hit_t  hits0;
  inst_hit_t  hits1;
  ex_ctrl_t   ctrl0;
  ex_ctrl_t   ctrl1;
  hazard_t    hz0;
  hazard_t    hz1;
  ex_bundle_t bundle0;
  ex_bundle_t bundle1;

  // lane 0 on ports 0 and 1
  op_match u_match0 (
    .instr (if_slot0.instr),
    .hits  (hits0)
  );

  ctrl_gen u_ctrl0 (
    .instr     (if_slot0.instr),
    .hits      (hits0),
    .ctrl      (ctrl0),
    .raddr_rj  (rf_raddr[0]),
    .raddr_rkd (rf_raddr[1]),
    .hz        (hz0)
  );

  // lane 1 on ports 2 and 3
  op_match u_match1 (
    .instr (if_slot1.instr),
    .hits  (hits1)
  );

  ctrl_gen u_ctrl1 (
    .instr     (if_slot1.instr),
    .hits      (hits1),
    .ctrl      (ctrl1),
    .raddr_rj  (rf_raddr[2]),
    .raddr_rkd (rf_raddr[3]),
    .hz        (hz1)
  );

  assign bundle0 = '{ctrl:       ctrl0,
                     rj_value:   rf_rdata[0],
                     rkd_value:  rf_rdata[1],
                     pc:         if_slot0.pc,
                     pc_is_jump: if_slot0.pc_is_jump};

  assign bundle1 = '{ctrl:       ctrl1,
                     rj_value:   rf_rdata[2],
                     rkd_value:  rf_rdata[3],
                     pc:         if_slot1.pc,
                     pc_is_jump: if_slot1.pc_is_jump};

  dual_issue u_issue (
    .clk        (clk),
    .rst_n      (rst_n),
    .if_valid0  (if_valid0),
    .if_valid1  (if_valid1),
    .hz0        (hz0),
    .hz1        (hz1),
    .raddr1_rj  (rf_raddr[2]),
    .raddr1_rkd (rf_raddr[3]),
    .bundle0    (bundle0),
    .bundle1    (bundle1),
    .ex_ready   (ex_ready),
    .flush      (flush),
    .pop        (pop),
    .ex_instr0  (ex_instr0),
    .ex_instr1  (ex_instr1),
    .ex_valid0  (ex_valid0),
    .ex_valid1  (ex_valid1)
  );

endmodule

// File: la_decode.f
+incdir+tb
common/la_decode_pkg.sv
decoder/op_match.sv
decoder/ctrl_gen.sv
hdl/dual_issue.sv
hdl/id_stage.sv
tb/tb_id_stage.sv

// File: tb/id_ref_model.svh
`ifndef ID_REF_MODEL_SVH
`define ID_REF_MODEL_SVH

// expected execute register, one entry per slot
ex_bundle_t exp_instr0 = '0;
ex_bundle_t exp_instr1 = '0;
logic       exp_v0 = 1'b0;
logic       exp_v1 = 1'b0;

// register file stand-in, address repeated into every byte
function automatic logic [31:0] rf_val(input logic [4:0] a);
  return {4{3'b000, a}};
endfunction

// stores and conditional branches read rd as second operand
function automatic logic [4:0] ref_rkd_addr(input int cls, input logic [31:0] w);
  return (cls == 4 || cls == 5) ? w[4:0] : w[14:10];
endfunction

function automatic ex_ctrl_t ref_ctrl(input int cls, input int idx, input logic [31:0] w);
  ex_ctrl_t    c;
  logic [43:0] a3r;
  logic [23:0] a12;
  logic [23:0] abr;
  logic [19:0] wld;
  logic [11:0] wst;
  // alu bit per index, one nibble each, index 0 lowest
  a3r = 44'ha9876453210;
  a12 = 24'h764032;
  abr = 24'h332211;
  // byte masks per load and store index
  wld = 20'h31f31;
  wst = 12'hf31;
  c = '0;
  c.dest = (cls == 8) ? RA_REG : w[4:0];
  case (cls)
    0: begin
      c.alu_op[a3r[idx*4 +: 4]] = 1'b1;
      c.gr_we = 1'b1;
    end
    1: begin
      c.alu_op[8 + idx] = 1'b1;
      c.src2_is_imm = 1'b1;
      c.imm = {27'b0, w[14:10]};
      c.gr_we = 1'b1;
    end
    2: begin
      c.alu_op[a12[idx*4 +: 4]] = 1'b1;
      c.src2_is_imm = 1'b1;
      // andi, ori and xori zero-extend
      c.imm = (idx >= 3) ? {20'b0, w[21:10]} : {{20{w[21]}}, w[21:10]};
      c.gr_we = 1'b1;
    end
    3, 4: begin
      c.alu_op[0] = 1'b1;
      c.src2_is_imm = 1'b1;
      c.imm = {{20{w[21]}}, w[21:10]};
      c.gr_we = (cls == 3);
      c.mem_we = (cls == 4);
      c.res_from_mem = (cls == 3);
      c.is_unsigned = (cls == 3) && (idx >= 3);
      c.bit_width = (cls == 3) ? wld[idx*4 +: 4] : wst[idx*4 +: 4];
    end
    5: begin
      c.alu_op[abr[idx*4 +: 4]] = 1'b1;
      c.may_jump = 1'b1;
      c.use_zero = (idx < 2);
      c.need_zero = (idx == 0);
      c.use_less = (idx >= 2);
      c.need_less = (idx == 2) || (idx == 4);
      c.imm = {{16{w[25]}}, w[25:10]};
    end
    6: begin
      c.alu_op[0] = 1'b1;
      c.may_jump = 1'b1;
      c.use_rj_value = 1'b1;
      c.src1_is_pc = 1'b1;
      c.src2_is_4 = 1'b1;
      c.gr_we = 1'b1;
      c.imm = {{16{w[25]}}, w[25:10]};
    end
    7, 8: begin
      c.may_jump = 1'b1;
      c.imm = {{6{w[9]}}, w[9:0], w[25:10]};
      c.alu_op[0] = (cls == 8);
      c.src1_is_pc = (cls == 8);
      c.src2_is_4 = (cls == 8);
      c.gr_we = (cls == 8);
    end
    default: begin
      c.alu_op[(cls == 9) ? 11 : 0] = 1'b1;
      c.src1_is_pc = (cls == 10);
      c.src2_is_imm = 1'b1;
      c.gr_we = 1'b1;
      c.imm = {w[24:5], 12'b0};
    end
  endcase
  return c;
endfunction

function automatic logic ref_issue1(input ex_ctrl_t c0, input int cls0, input ex_ctrl_t c1,
                                    input int cls1, input logic [31:0] w1);
  logic ls;
  logic rd_rj;
  logic rd_rkd;
  logic raw;
  ls = (cls0 == 3) || (cls0 == 4) || (cls1 == 3) || (cls1 == 4);
  rd_rj = c1.use_rj_value || !c1.src1_is_pc;
  rd_rkd = !(c1.src2_is_imm || c1.src2_is_4);
  raw = c0.gr_we && (c0.dest != 5'd0) &&
        ((rd_rj && c0.dest == w1[9:5]) || (rd_rkd && c0.dest == ref_rkd_addr(cls1, w1)));
  return !(c0.may_jump || ls || raw);
endfunction

function automatic ex_bundle_t ref_bundle(input ex_ctrl_t c, input int cls, input if_slot_t s);
  ex_bundle_t b;
  b.ctrl = c;
  b.rj_value = rf_val(s.instr[9:5]);
  b.rkd_value = rf_val(ref_rkd_addr(cls, s.instr));
  b.pc = s.pc;
  b.pc_is_jump = s.pc_is_jump;
  return b;
endfunction

task automatic model_clock(input logic clr, input logic rdy, input logic iss0, input logic iss1,
                           input ex_bundle_t b0, input ex_bundle_t b1);
  if (clr) begin
    exp_instr0 = '0;
    exp_instr1 = '0;
    exp_v0 = 1'b0;
    exp_v1 = 1'b0;
  end else if (rdy) begin
    exp_instr0 = b0;
    exp_instr1 = b1;
    exp_v0 = iss0;
    exp_v1 = iss1;
  end
endtask

`endif

// File: tb/tb_id_stage.sv
`timescale 1ns/100ps
module tb_id_stage;
  import la_decode_pkg::*;

  logic                       clk;
  logic                       rst_n;
  if_slot_t                   if_slot0;
  if_slot_t                   if_slot1;
  logic                       if_valid0;
  logic                       if_valid1;
  logic [3:0][XLEN-1:0]       rf_rdata;
  logic                       ex_ready;
  logic                       flush;
  logic [1:0]                 pop;
  logic [3:0][REG_ADDR_W-1:0] rf_raddr;
  ex_bundle_t                 ex_instr0;
  ex_bundle_t                 ex_instr1;
  logic                       ex_valid0;
  logic                       ex_valid1;

  logic [31:0] lfsr;
  int          cls0;
  int          idx0;
  int          cls1;
  int          idx1;

  `include "id_ref_model.svh"

  id_stage u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .if_slot0  (if_slot0),
    .if_slot1  (if_slot1),
    .if_valid0 (if_valid0),
    .if_valid1 (if_valid1),
    .rf_rdata  (rf_rdata),
    .ex_ready  (ex_ready),
    .flush     (flush),
    .pop       (pop),
    .rf_raddr  (rf_raddr),
    .ex_instr0 (ex_instr0),
    .ex_instr1 (ex_instr1),
    .ex_valid0 (ex_valid0),
    .ex_valid1 (ex_valid1)
  );

  always_comb begin
    for (int i = 0; i < 4; i++)
      rf_rdata[i] = rf_val(rf_raddr[i]);
  end

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  task automatic compare_values(input logic [255:0] got, input logic [255:0] exp,
                                input string msg);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, msg, got, exp);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  // mode 0 alu, 1 memory, 2 branch or jump, 3 anything kept
  task automatic gen_instr(input int mode, output logic [31:0] w, output int cls,
                           output int idx);
    logic [54:0] t3r;
    logic [14:0] tsh;
    logic [23:0] t12;
    logic [19:0] tld;
    logic [11:0] tst;
    logic [35:0] tbr;
    logic [4:0]  rd;
    logic [4:0]  rj;
    logic [4:0]  rk;
    logic [15:0] off;
    logic [19:0] si20;
    int          c;
    int          n;
    t3r = {OP5_SRA, OP5_SRL, OP5_SLL, OP5_XOR, OP5_OR, OP5_AND, OP5_NOR, OP5_SLTU, OP5_SLT,
           OP5_SUB, OP5_ADD};
    tsh = {OP5_SRAI, OP5_SRLI, OP5_SLLI};
    t12 = {OP4_XORI, OP4_ORI, OP4_ANDI, OP4_ADDI, OP4_SLTUI, OP4_SLTI};
    tld = {OP4_LD_HU, OP4_LD_BU, OP4_LD_W, OP4_LD_H, OP4_LD_B};
    tst = {OP4_ST_W, OP4_ST_H, OP4_ST_B};
    tbr = {OP6_BGEU, OP6_BLTU, OP6_BGE, OP6_BLT, OP6_BNE, OP6_BEQ};
    case (mode)
      0: begin
        c = rand_bits(4) % 5;
        cls = (c < 3) ? c : c + 6;
      end
      1: cls = 3 + rand_bits(1);
      2: cls = 5 + rand_bits(2);
      default: cls = rand_bits(5) % 11;
    endcase
    n = (cls == 0) ? 11 : (cls == 2 || cls == 5) ? 6 : (cls == 3) ? 5 :
        (cls == 1 || cls == 4) ? 3 : 1;
    idx = rand_bits(8) % n;
    // few registers so that pairs collide often
    rd = rand_bits(3);
    rj = rand_bits(3);
    rk = rand_bits(3);
    off = rand_bits(16);
    si20 = rand_bits(20);
    case (cls)
      0: w = {OP6_ALU, OP4_3R, OP2_3R, t3r[idx*5 +: 5], rk, rj, rd};
      1: w = {OP6_ALU, OP4_SHIFTI, OP2_SHIFTI, tsh[idx*5 +: 5], off[4:0], rj, rd};
      2: w = {OP6_ALU, t12[idx*4 +: 4], off[11:0], rj, rd};
      3: w = {OP6_MEM, tld[idx*4 +: 4], off[11:0], rj, rd};
      4: w = {OP6_MEM, tst[idx*4 +: 4], off[11:0], rj, rd};
      5: w = {tbr[idx*6 +: 6], off, rj, rd};
      6: w = {OP6_JIRL, off, rj, rd};
      7: w = {OP6_B, off, si20[9:0]};
      8: w = {OP6_BL, off, si20[9:0]};
      9: w = {OP7_LU12I, si20, rd};
      default: w = {OP7_PCADDU, si20, rd};
    endcase
  endtask

  task automatic load_slots(input int mode0, input int mode1);
    logic [31:0] w;
    gen_instr(mode0, w, cls0, idx0);
    if_slot0.pc = rand_bits(30) << 2;
    if_slot0.instr = w;
    if_slot0.pc_is_jump = rand_bits(1);
    gen_instr(mode1, w, cls1, idx1);
    if_slot1.pc = if_slot0.pc + 32'd4;
    if_slot1.instr = w;
    if_slot1.pc_is_jump = rand_bits(1);
  endtask

  // inputs at edge plus 1 ns, checks mid-cycle, model steps with the edge
  task automatic cycle(input logic v0, input logic v1, input logic rdy, input logic fl);
    ex_ctrl_t c0;
    ex_ctrl_t c1;
    logic     iss0;
    logic     iss1;
    if_valid0 = v0;
    if_valid1 = v1;
    ex_ready = rdy;
    flush = fl;
    c0 = ref_ctrl(cls0, idx0, if_slot0.instr);
    c1 = ref_ctrl(cls1, idx1, if_slot1.instr);
    iss0 = v0;
    iss1 = v0 && v1 && ref_issue1(c0, cls0, c1, cls1, if_slot1.instr);
    #4;
    compare_values(ex_valid0, exp_v0, "ex_valid0");
    compare_values(ex_valid1, exp_v1, "ex_valid1");
    compare_values(ex_instr0, exp_instr0, "ex_instr0");
    compare_values(ex_instr1, exp_instr1, "ex_instr1");
    compare_values(pop, {iss1 & rdy, iss0 & rdy}, "pop");
    if (v0) begin
      compare_values(rf_raddr[0], if_slot0.instr[9:5], "rf_raddr[0]");
      compare_values(rf_raddr[1], ref_rkd_addr(cls0, if_slot0.instr), "rf_raddr[1]");
    end
    if (v1) begin
      compare_values(rf_raddr[2], if_slot1.instr[9:5], "rf_raddr[2]");
      compare_values(rf_raddr[3], ref_rkd_addr(cls1, if_slot1.instr), "rf_raddr[3]");
    end
    model_clock(fl, rdy, iss0, iss1, ref_bundle(c0, cls0, if_slot0),
                ref_bundle(c1, cls1, if_slot1));
    @(posedge clk);
    #1;
  endtask

  task automatic wait_ex_idle(input int max_cycles);
    int n;
    n = 0;
    while (ex_valid0 || ex_valid1) begin
      if (n == max_cycles) begin
        $display("timeout: execute valids did not clear within %0d cycles", max_cycles);
        $display("Testbench failed");
        $fatal(1);
      end
      cycle(1'b0, 1'b0, 1'b1, 1'b0);
      n++;
    end
    compare_values(ex_valid0, exp_v0, "ex_valid0 when idle");
    compare_values(ex_valid1, exp_v1, "ex_valid1 when idle");
  endtask

  initial begin
    int n;
    lfsr = 32'd80;
    rst_n = 1'b0;
    if_slot0 = '0;
    if_slot1 = '0;
    if_valid0 = 1'b0;
    if_valid1 = 1'b0;
    ex_ready = 1'b0;
    flush = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    load_slots(3, 3);
    repeat (4) cycle(1'b0, 1'b0, 1'b1, 1'b0);
    // slot 0 alone
    repeat (80) begin
      load_slots(0, 0);
      cycle(1'b1, 1'b0, 1'b1, 1'b0);
    end
    repeat (50) begin
      load_slots(1, 1);
      cycle(1'b1, 1'b0, 1'b1, 1'b0);
    end
    // branch in slot 0 holds back slot 1
    repeat (50) begin
      load_slots(2, 3);
      cycle(1'b1, 1'b1, 1'b1, 1'b0);
    end
    repeat (400) begin
      load_slots(3, 3);
      cycle(1'b1, 1'b1, 1'b1, 1'b0);
    end
    repeat (60) begin
      load_slots(3, 3);
      cycle(1'b1, 1'b1, 1'b1, 1'b0);
      n = rand_bits(3);
      repeat (n) cycle(1'b1, 1'b1, 1'b0, 1'b0);
      if (rand_bits(2) == 0) begin
        cycle(1'b1, 1'b1, 1'b1, 1'b1);
        wait_ex_idle(4);
      end
    end
    wait_ex_idle(4);
    $display("Testbench passed");
    $finish;
  end

endmodule
